// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = soc_ifc_regs_tb
FILELIST  = src.f
OBJDIR    = obj_dir
PASS_MSG  = Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// ==== sim/soc_ifc_regs_assert.sv ====
/*
 * Concurrent checks on the APB response of the register slice
 * Single-cycle pready, error only with pready, fixed latency
 */
`timescale 1ns/10ps

module soc_ifc_regs_assert (
    input logic clk,
    input logic cptra_noncore_rst_b,
    input logic psel_i,
    input logic penable_i,
    input logic pready_i,
    input logic pslverr_i
);

    // pready lasts one cycle
    a_ready_single: assert property (@(posedge clk) disable iff (!cptra_noncore_rst_b)
        pready_i |=> !pready_i)
        else $error("pready_o high two cycles in a row");

    a_err_with_ready: assert property (@(posedge clk) disable iff (!cptra_noncore_rst_b)
        pslverr_i |-> pready_i)
        else $error("pslverr_o high without pready_o");

    // Access phase start to pready, four cycles
    a_fixed_latency: assert property (@(posedge clk) disable iff (!cptra_noncore_rst_b)
        $rose(psel_i && penable_i) |->
            !pready_i ##1 !pready_i ##1 !pready_i ##1 !pready_i ##1 pready_i)
        else $error("pready_o not 4 cycles after access start");

endmodule

bind soc_ifc_regs_top soc_ifc_regs_assert u_regs_assert (
    .clk                 (clk),
    .cptra_noncore_rst_b (cptra_noncore_rst_b),
    .psel_i              (psel_i),
    .penable_i           (penable_i),
    .pready_i            (pready_o),
    .pslverr_i           (pslverr_o)
);

// ==== sim/soc_ifc_regs_stimulus.txt ====
// Columns, hex: op (0 read, 1 write), paddr, pwdata, pauser, expected prdata, expected pslverr
// One APB transfer per line, applied in order
0 30000 00000000 00000000 00000000 0
0 30004 00000000 00000000 00000000 0
0 30008 00000000 00000000 00000000 0
0 3000C 00000000 00000000 00000000 0
0 30010 00000000 00000000 00000000 0
0 30040 00000000 00000000 00000000 0
0 30044 00000000 00000000 00000000 0
0 30048 00000000 00000000 00000000 0
0 3004C 00000000 00000000 00000000 0
0 30080 00000000 00000000 00000000 0
0 30084 00000000 00000000 00000000 0
0 30088 00000000 00000000 00000000 0
0 3008C 00000000 00000000 00000000 0
1 30080 11111111 00000000 00000000 0
1 3008C 22222222 00000000 00000000 0
0 30080 00000000 00000000 11111111 0
1 30000 00000001 00000000 00000000 0
1 30080 DEADBEEF 00000000 00000000 0
0 30080 00000000 00000000 11111111 0
1 30000 00000000 00000000 00000000 0
0 30000 00000000 00000000 00000001 0
0 3008C 00000000 00000000 22222222 0
1 30004 A5A50001 00000000 00000000 0
0 30004 00000000 00000000 A5A50001 0
1 30008 00000001 00000000 00000000 0
1 30004 12345678 00000000 00000000 0
0 30004 00000000 00000000 A5A50001 0
1 30008 00000000 00000000 00000000 0
0 30008 00000000 00000000 00000001 0
1 3000C CAFE0001 00000000 00000000 0
1 30010 00000001 00000000 00000000 0
1 3000C 00000000 00000000 00000000 0
0 3000C 00000000 00000000 CAFE0001 0
1 30044 55AA55AA CAFE0001 00000000 0
0 30044 00000000 00000000 55AA55AA 0
1 30044 0BADF00D 00000007 00000000 0
0 30044 00000000 00000000 55AA55AA 0
0 20000 00000000 00000000 00000000 1
1 31044 FFFFFFFF CAFE0001 00000000 1
0 30014 00000000 00000000 00000000 1
0 30050 00000000 00000000 00000000 1
1 30090 FFFFFFFF 00000000 00000000 1
1 30046 FFFFFFFF CAFE0001 00000000 1
0 30044 00000000 00000000 55AA55AA 0
0 30088 00000000 00000000 00000000 0

// ==== sim/soc_ifc_regs_tb.sv ====
/*
 * Testbench for the SoC interface register slice
 * Clock and reset, APB transfers read from a stimulus file,
 * response and latency checks, closing summary
 */
`timescale 1ns/10ps

module soc_ifc_regs_tb;

    localparam int          ADDR_W     = 18;
    localparam int          MAX_XFERS  = 64;
    localparam int          FIELDS     = 6;
    localparam int          WAIT_LIMIT = 32;
    localparam int          EXP_LAT    = 4;
    localparam logic [15:0] LFSR_SEED  = 16'd43387;

    logic              clk;
    logic              cptra_noncore_rst_b;
    logic [ADDR_W-1:0] paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [31:0]       pwdata;
    logic [31:0]       pauser;
    logic              pready_o;
    logic [31:0]       prdata_o;
    logic              pslverr_o;

    // One transfer per FIELDS words, in file column order
    logic [31:0] stim_mem [FIELDS*MAX_XFERS];

    int          data_errors;
    int          slverr_errors;
    int          latency_errors;
    int          timeouts;
    int          file_errors;
    int          n;
    logic [1:0]  gap;
    logic [15:0] lfsr;

    soc_ifc_regs_top #(
        .APB_ADDR_WIDTH (ADDR_W),
        .UDS_WORDS      (4),
        .TRNG_WORDS     (4)
    ) dut_i (
        .clk                 (clk),
        .cptra_noncore_rst_b (cptra_noncore_rst_b),
        .paddr_i             (paddr),
        .psel_i              (psel),
        .penable_i           (penable),
        .pwrite_i            (pwrite),
        .pwdata_i            (pwdata),
        .pauser_i            (pauser),
        .pready_o            (pready_o),
        .prdata_o            (prdata_o),
        .pslverr_o           (pslverr_o)
    );

    always #4 clk = ~clk;

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_advance(input logic [15:0] s);
        logic lsb;
        lsb = s[0];
        s   = s >> 1;
        if (lsb) s = s ^ 16'hB400;
        return s;
    endfunction

    ////////////////////
    // One APB transfer with its response check
    task automatic run_transfer(input int idx);
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] user;
        logic [31:0] exp_rdata;
        logic [31:0] exp_err;
        int          waited;
        op        = stim_mem[FIELDS*idx];
        addr      = stim_mem[FIELDS*idx+1];
        wdata     = stim_mem[FIELDS*idx+2];
        user      = stim_mem[FIELDS*idx+3];
        exp_rdata = stim_mem[FIELDS*idx+4];
        exp_err   = stim_mem[FIELDS*idx+5];
        // Setup phase
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= op[0];
        paddr   <= addr[ADDR_W-1:0];
        pwdata  <= wdata;
        pauser  <= user;
        // Access phase, held until pready_o
        @(posedge clk);
        penable <= 1'b1;
        waited = 0;
        @(negedge clk);
        while (!pready_o && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!pready_o) begin
            $display("Timeout at %0t: pready_o never rose for transfer %0d", $time, idx);
            timeouts++;
        end else begin
            assert (waited == EXP_LAT) else begin
                $display("CHECK FAILED t=%0t pready_o latency got %0d expected %0d",
                         $time, waited, EXP_LAT);
                latency_errors++;
            end
            assert (prdata_o == exp_rdata) else begin
                $display("CHECK FAILED t=%0t prdata_o got %h expected %h (transfer %0d)",
                         $time, prdata_o, exp_rdata, idx);
                data_errors++;
            end
            assert (pslverr_o == exp_err[0]) else begin
                $display("CHECK FAILED t=%0t pslverr_o got %b expected %b (transfer %0d)",
                         $time, pslverr_o, exp_err[0], idx);
                slverr_errors++;
            end
        end
    endtask

    initial begin
        clk                 = 1'b0;
        cptra_noncore_rst_b = 1'b0;
        paddr               = '0;
        psel                = 1'b0;
        penable             = 1'b0;
        pwrite              = 1'b0;
        pwdata              = '0;
        pauser              = '0;
        data_errors         = 0;
        slverr_errors       = 0;
        latency_errors      = 0;
        timeouts            = 0;
        file_errors         = 0;
        gap                 = '0;
        lfsr                = LFSR_SEED;

        // Unused slots hold no valid opcode, which ends the list
        for (int i = 0; i < FIELDS*MAX_XFERS; i++) begin
            stim_mem[i] = 32'hEE00_0000 | 32'(i);
        end
        $readmemh("sim/soc_ifc_regs_stimulus.txt", stim_mem);

        repeat (3) @(posedge clk);
        cptra_noncore_rst_b <= 1'b1;

        n = 0;
        while (n < MAX_XFERS && stim_mem[FIELDS*n] <= 32'd1 && timeouts == 0) begin
            // Idle gap of 0 to 3 cycles, one LFSR step per bit
            for (int b = 0; b < 2; b++) begin
                gap  = {gap[0], lfsr[0]};
                lfsr = lfsr_advance(lfsr);
            end
            repeat (gap) begin
                @(posedge clk);
                psel    <= 1'b0;
                penable <= 1'b0;
            end
            run_transfer(n);
            n++;
        end
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;

        if (n == 0) begin
            $display("No transfers were read from the stimulus file");
            file_errors++;
        end

        $display("Errors: read data %0d, slave error %0d, latency %0d, timeouts %0d, file %0d",
                 data_errors, slverr_errors, latency_errors, timeouts, file_errors);
        if (data_errors + slverr_errors + latency_errors + timeouts + file_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== source/access_check_stage.sv ====
/*
 * Address decode and write permission check
 * Maps the APB address onto a register and word index, then
 * applies the fuse-done, lock and TRNG user rules
 */
`timescale 1ns/10ps

module access_check_stage #(
    parameter int APB_ADDR_WIDTH = 18,
    parameter int UDS_WORDS      = 4,
    parameter int TRNG_WORDS     = 4
) (
    input  logic                                         clk,
    input  logic                                         cptra_noncore_rst_b,

    input  logic                                         req_valid_i,
    input  soc_ifc_access_pkg::access_op_e               req_op_i,
    input  logic [APB_ADDR_WIDTH-1:0]                    req_addr_i,
    input  logic [soc_ifc_cfg_pkg::SOC_IFC_DATA_W-1:0]   req_wdata_i,
    input  logic [soc_ifc_cfg_pkg::SOC_IFC_USER_W-1:0]   req_user_i,

    input  logic                                         fuse_done_i,
    input  logic                                         pauser_lock_i,
    input  logic                                         trng_lock_i,
    input  logic [soc_ifc_cfg_pkg::SOC_IFC_USER_W-1:0]   trng_valid_user_i,

    output logic                                         chk_valid_o,
    output soc_ifc_access_pkg::access_op_e               chk_op_o,
    output soc_ifc_cfg_pkg::reg_id_e                     chk_id_o,
    output logic [soc_ifc_cfg_pkg::SOC_IFC_REG_AW-3:0]   chk_index_o,
    output logic [soc_ifc_cfg_pkg::SOC_IFC_DATA_W-1:0]   chk_wdata_o,
    output soc_ifc_access_pkg::access_res_e              chk_res_o
);

    import soc_ifc_cfg_pkg::*;
    import soc_ifc_access_pkg::*;

    // Word address width inside the window
    localparam int IW = SOC_IFC_REG_AW - 2;
    localparam logic [IW-1:0] TRNG_BASE = TRNG_DATA_OFS[SOC_IFC_REG_AW-1:2];
    localparam logic [IW-1:0] UDS_BASE  = UDS_SEED_OFS[SOC_IFC_REG_AW-1:2];
    localparam logic [IW-1:0] TRNG_N    = IW'(TRNG_WORDS);
    localparam logic [IW-1:0] UDS_N     = IW'(UDS_WORDS);

    logic [IW-1:0] word;
    logic [IW-1:0] trng_rel;
    logic [IW-1:0] uds_rel;
    logic          in_window;
    reg_id_e       id;
    logic [IW-1:0] index;
    logic          blocked;
    access_res_e   res;

    ////////////////////
    // Address decode
    always_comb begin
        word      = req_addr_i[SOC_IFC_REG_AW-1:2];
        trng_rel  = word - TRNG_BASE;
        uds_rel   = word - UDS_BASE;
        in_window = (req_addr_i[APB_ADDR_WIDTH-1:SOC_IFC_REG_AW] ==
                     SOC_IFC_REG_BASE[APB_ADDR_WIDTH-1:SOC_IFC_REG_AW]) &&
                    (req_addr_i[1:0] == 2'b00);
        id        = REG_NONE;
        index     = '0;
        if (in_window) begin
            if (word == FUSE_WR_DONE_OFS[SOC_IFC_REG_AW-1:2]) begin
                id = REG_FUSE_DONE;
            end else if (word == VALID_PAUSER_OFS[SOC_IFC_REG_AW-1:2]) begin
                id = REG_VALID_PAUSER;
            end else if (word == PAUSER_LOCK_OFS[SOC_IFC_REG_AW-1:2]) begin
                id = REG_PAUSER_LOCK;
            end else if (word == TRNG_VALID_PAUSER_OFS[SOC_IFC_REG_AW-1:2]) begin
                id = REG_TRNG_PAUSER;
            end else if (word == TRNG_PAUSER_LOCK_OFS[SOC_IFC_REG_AW-1:2]) begin
                id = REG_TRNG_LOCK;
            end else if (word >= TRNG_BASE && trng_rel < TRNG_N) begin
                id    = REG_TRNG_DATA;
                index = trng_rel;
            end else if (word >= UDS_BASE && uds_rel < UDS_N) begin
                id    = REG_UDS_SEED;
                index = uds_rel;
            end
        end
    end

    ////////////////////
    // Write rules
    always_comb begin
        case (id)
            REG_FUSE_DONE, REG_UDS_SEED:     blocked = fuse_done_i;
            REG_VALID_PAUSER, REG_PAUSER_LOCK: blocked = pauser_lock_i;
            REG_TRNG_PAUSER, REG_TRNG_LOCK:  blocked = trng_lock_i;
            // Only the TRNG owner may fill the data words
            REG_TRNG_DATA:                   blocked = (req_user_i != trng_valid_user_i);
            default:                         blocked = 1'b0;
        endcase
        if (id == REG_NONE) begin
            res = RES_DECODE_ERR;
        end else if (req_op_i == OP_WRITE && blocked) begin
            res = RES_IGNORED;
        end else begin
            res = RES_OK;
        end
    end

    always_ff @(posedge clk or negedge cptra_noncore_rst_b) begin
        if (!cptra_noncore_rst_b) begin
            chk_valid_o <= 1'b0;
        end else begin
            chk_valid_o <= req_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            chk_op_o    <= req_op_i;
            chk_id_o    <= id;
            chk_index_o <= index;
            chk_wdata_o <= req_wdata_i;
            chk_res_o   <= res;
        end
    end

endmodule

// ==== source/apb_req_stage.sv ====
/*
 * APB slave front end
 * Captures one access phase, issues a request strobe and
 * drives the response onto the bus for a single cycle
 */
`timescale 1ns/10ps

module apb_req_stage #(
    parameter int APB_ADDR_WIDTH = 18
) (
    input  logic                                         clk,
    input  logic                                         cptra_noncore_rst_b,

    input  logic [APB_ADDR_WIDTH-1:0]                    paddr_i,
    input  logic                                         psel_i,
    input  logic                                         penable_i,
    input  logic                                         pwrite_i,
    input  logic [soc_ifc_cfg_pkg::SOC_IFC_DATA_W-1:0]   pwdata_i,
    input  logic [soc_ifc_cfg_pkg::SOC_IFC_USER_W-1:0]   pauser_i,
    output logic                                         pready_o,
    output logic [soc_ifc_cfg_pkg::SOC_IFC_DATA_W-1:0]   prdata_o,
    output logic                                         pslverr_o,

    input  logic                                         rsp_valid_i,
    input  logic [soc_ifc_cfg_pkg::SOC_IFC_DATA_W-1:0]   rsp_rdata_i,
    input  logic                                         rsp_err_i,

    output logic                                         req_valid_o,
    output soc_ifc_access_pkg::access_op_e               req_op_o,
    output logic [APB_ADDR_WIDTH-1:0]                    req_addr_o,
    output logic [soc_ifc_cfg_pkg::SOC_IFC_DATA_W-1:0]   req_wdata_o,
    output logic [soc_ifc_cfg_pkg::SOC_IFC_USER_W-1:0]   req_user_o
);

    import soc_ifc_access_pkg::*;

    req_state_e state_q;
    logic       start;

    // Access phase seen while nothing is in flight
    assign start = (state_q == REQ_IDLE) && psel_i && penable_i;

    ////////////////////
    // Control and response
    always_ff @(posedge clk or negedge cptra_noncore_rst_b) begin
        if (!cptra_noncore_rst_b) begin
            state_q     <= REQ_IDLE;
            req_valid_o <= 1'b0;
            pready_o    <= 1'b0;
            prdata_o    <= '0;
            pslverr_o   <= 1'b0;
        end else begin
            req_valid_o <= start;
            pready_o    <= rsp_valid_i;
            pslverr_o   <= rsp_valid_i && rsp_err_i;
            prdata_o    <= rsp_valid_i ? rsp_rdata_i : '0;
            case (state_q)
                REQ_IDLE: if (start) state_q <= REQ_BUSY;
                // Free again once the response has been on the bus
                REQ_BUSY: if (pready_o) state_q <= REQ_IDLE;
                default:  state_q <= REQ_IDLE;
            endcase
        end
    end

    // Request fields, held until the next transfer
    always_ff @(posedge clk) begin
        if (start) begin
            req_op_o    <= pwrite_i ? OP_WRITE : OP_READ;
            req_addr_o  <= paddr_i;
            req_wdata_o <= pwdata_i;
            req_user_o  <= pauser_i;
        end
    end

endmodule

// ==== source/fuse_reg_bank.sv ====
/*
 * Fuse and user register storage
 * Sticky done and lock bits, UDS seed and TRNG data words,
 * registered read data and error response
 */
`timescale 1ns/10ps

module fuse_reg_bank #(
    parameter int UDS_WORDS  = 4,
    parameter int TRNG_WORDS = 4
) (
    input  logic                                         clk,
    input  logic                                         cptra_noncore_rst_b,

    input  logic                                         chk_valid_i,
    input  soc_ifc_access_pkg::access_op_e               chk_op_i,
    input  soc_ifc_cfg_pkg::reg_id_e                     chk_id_i,
    input  logic [soc_ifc_cfg_pkg::SOC_IFC_REG_AW-3:0]   chk_index_i,
    input  logic [soc_ifc_cfg_pkg::SOC_IFC_DATA_W-1:0]   chk_wdata_i,
    input  soc_ifc_access_pkg::access_res_e              chk_res_i,

    output logic                                         rsp_valid_o,
    output logic [soc_ifc_cfg_pkg::SOC_IFC_DATA_W-1:0]   rsp_rdata_o,
    output logic                                         rsp_err_o,

    output logic                                         fuse_done_o,
    output logic                                         pauser_lock_o,
    output logic                                         trng_lock_o,
    output logic [soc_ifc_cfg_pkg::SOC_IFC_USER_W-1:0]   trng_valid_user_o
);

    import soc_ifc_cfg_pkg::*;
    import soc_ifc_access_pkg::*;

    localparam int IW = SOC_IFC_REG_AW - 2;

    logic                      fuse_done_q;
    logic                      pauser_lock_q;
    logic                      trng_lock_q;
    logic [SOC_IFC_DATA_W-1:0] valid_pauser_q;
    logic [SOC_IFC_DATA_W-1:0] trng_pauser_q;
    logic [SOC_IFC_DATA_W-1:0] trng_data_q [TRNG_WORDS];
    logic [SOC_IFC_DATA_W-1:0] uds_seed_q [UDS_WORDS];

    logic                      wr_en;
    logic                      rd_en;
    logic [SOC_IFC_DATA_W-1:0] rd_data;

    assign wr_en = chk_valid_i && (chk_op_i == OP_WRITE) && (chk_res_i == RES_OK);
    assign rd_en = chk_valid_i && (chk_op_i == OP_READ) && (chk_res_i == RES_OK);

    ////////////////////
    // Register writes
    always_ff @(posedge clk or negedge cptra_noncore_rst_b) begin
        if (!cptra_noncore_rst_b) begin
            fuse_done_q    <= 1'b0;
            pauser_lock_q  <= 1'b0;
            trng_lock_q    <= 1'b0;
            valid_pauser_q <= '0;
            trng_pauser_q  <= '0;
            for (int i = 0; i < TRNG_WORDS; i++) trng_data_q[i] <= '0;
            for (int i = 0; i < UDS_WORDS; i++) uds_seed_q[i] <= '0;
        end else if (wr_en) begin
            case (chk_id_i)
                // Done and lock bits only ever set until reset
                REG_FUSE_DONE:    fuse_done_q   <= fuse_done_q | chk_wdata_i[0];
                REG_PAUSER_LOCK:  pauser_lock_q <= pauser_lock_q | chk_wdata_i[0];
                REG_TRNG_LOCK:    trng_lock_q   <= trng_lock_q | chk_wdata_i[0];
                REG_VALID_PAUSER: valid_pauser_q <= chk_wdata_i;
                REG_TRNG_PAUSER:  trng_pauser_q  <= chk_wdata_i;
                REG_TRNG_DATA: begin
                    for (int i = 0; i < TRNG_WORDS; i++) begin
                        if (chk_index_i == IW'(i)) trng_data_q[i] <= chk_wdata_i;
                    end
                end
                REG_UDS_SEED: begin
                    for (int i = 0; i < UDS_WORDS; i++) begin
                        if (chk_index_i == IW'(i)) uds_seed_q[i] <= chk_wdata_i;
                    end
                end
                default: ;
            endcase
        end
    end

    ////////////////////
    // Read mux
    always_comb begin
        rd_data = '0;
        case (chk_id_i)
            REG_FUSE_DONE:    rd_data[0] = fuse_done_q;
            REG_PAUSER_LOCK:  rd_data[0] = pauser_lock_q;
            REG_TRNG_LOCK:    rd_data[0] = trng_lock_q;
            REG_VALID_PAUSER: rd_data = valid_pauser_q;
            REG_TRNG_PAUSER:  rd_data = trng_pauser_q;
            REG_TRNG_DATA: begin
                for (int i = 0; i < TRNG_WORDS; i++) begin
                    if (chk_index_i == IW'(i)) rd_data = trng_data_q[i];
                end
            end
            REG_UDS_SEED: begin
                for (int i = 0; i < UDS_WORDS; i++) begin
                    if (chk_index_i == IW'(i)) rd_data = uds_seed_q[i];
                end
            end
            default: rd_data = '0;
        endcase
    end

    // Response back to the APB stage, data only for good reads
    always_ff @(posedge clk or negedge cptra_noncore_rst_b) begin
        if (!cptra_noncore_rst_b) begin
            rsp_valid_o <= 1'b0;
            rsp_rdata_o <= '0;
            rsp_err_o   <= 1'b0;
        end else begin
            rsp_valid_o <= chk_valid_i;
            rsp_rdata_o <= rd_en ? rd_data : '0;
            rsp_err_o   <= chk_valid_i && (chk_res_i == RES_DECODE_ERR);
        end
    end

    assign fuse_done_o       = fuse_done_q;
    assign pauser_lock_o     = pauser_lock_q;
    assign trng_lock_o       = trng_lock_q;
    assign trng_valid_user_o = trng_pauser_q[SOC_IFC_USER_W-1:0];

endmodule

// ==== source/soc_ifc_access_pkg.sv ====
/*
 * Access types carried through the register pipeline
 * Opcode, APB front end state and the check stage verdict
 */
package soc_ifc_access_pkg;

    // Direction of one APB transfer
    typedef enum logic {
        OP_READ,
        OP_WRITE
    } access_op_e;

    // APB front end, one transfer in flight at most
    typedef enum logic {
        REQ_IDLE,
        REQ_BUSY
    } req_state_e;

    // Verdict of the check stage
    typedef enum logic [1:0] {
        RES_OK,
        RES_IGNORED,
        RES_DECODE_ERR
    } access_res_e;

endpackage

// ==== source/soc_ifc_cfg_pkg.sv ====
/*
 * SoC interface register slice configuration
 * APB data and user widths, register window base and size,
 * byte offsets of each register and the register identifier enum
 */
package soc_ifc_cfg_pkg;

    ////////////////////
    // Bus widths
    localparam int SOC_IFC_DATA_W = 32;
    localparam int SOC_IFC_USER_W = 32;

    // Low address bits decoded inside the register window
    localparam int SOC_IFC_REG_AW = 12;

    ////////////////////
    // Register window
    localparam logic [31:0] SOC_IFC_REG_BASE = 32'h0003_0000;

    // Byte offsets inside the window
    localparam logic [SOC_IFC_REG_AW-1:0] FUSE_WR_DONE_OFS      = 12'h000;
    localparam logic [SOC_IFC_REG_AW-1:0] VALID_PAUSER_OFS      = 12'h004;
    localparam logic [SOC_IFC_REG_AW-1:0] PAUSER_LOCK_OFS       = 12'h008;
    localparam logic [SOC_IFC_REG_AW-1:0] TRNG_VALID_PAUSER_OFS = 12'h00C;
    localparam logic [SOC_IFC_REG_AW-1:0] TRNG_PAUSER_LOCK_OFS  = 12'h010;
    // Bases of the word arrays
    localparam logic [SOC_IFC_REG_AW-1:0] TRNG_DATA_OFS         = 12'h040;
    localparam logic [SOC_IFC_REG_AW-1:0] UDS_SEED_OFS          = 12'h080;

    ////////////////////
    // Decoded register
    typedef enum logic [2:0] {
        REG_NONE,
        REG_FUSE_DONE,
        REG_VALID_PAUSER,
        REG_PAUSER_LOCK,
        REG_TRNG_PAUSER,
        REG_TRNG_LOCK,
        REG_TRNG_DATA,
        REG_UDS_SEED
    } reg_id_e;

endpackage

// ==== source/soc_ifc_regs_top.sv ====
/*
 * SoC interface register slice top level
 * APB front end, check stage and register bank in a chain
 */
`timescale 1ns/10ps

module soc_ifc_regs_top #(
    parameter int APB_ADDR_WIDTH = 18,
    parameter int UDS_WORDS      = 4,
    parameter int TRNG_WORDS     = 4
) (
    input  logic                                         clk,
    input  logic                                         cptra_noncore_rst_b,

    input  logic [APB_ADDR_WIDTH-1:0]                    paddr_i,
    input  logic                                         psel_i,
    input  logic                                         penable_i,
    input  logic                                         pwrite_i,
    input  logic [soc_ifc_cfg_pkg::SOC_IFC_DATA_W-1:0]   pwdata_i,
    input  logic [soc_ifc_cfg_pkg::SOC_IFC_USER_W-1:0]   pauser_i,
    output logic                                         pready_o,
    output logic [soc_ifc_cfg_pkg::SOC_IFC_DATA_W-1:0]   prdata_o,
    output logic                                         pslverr_o
);

    import soc_ifc_cfg_pkg::*;
    import soc_ifc_access_pkg::*;

    // APB stage to check stage
    logic                      req_valid;
    access_op_e                req_op;
    logic [APB_ADDR_WIDTH-1:0] req_addr;
    logic [SOC_IFC_DATA_W-1:0] req_wdata;
    logic [SOC_IFC_USER_W-1:0] req_user;

    // Check stage to bank
    logic                      chk_valid;
    access_op_e                chk_op;
    reg_id_e                   chk_id;
    logic [SOC_IFC_REG_AW-3:0] chk_index;
    logic [SOC_IFC_DATA_W-1:0] chk_wdata;
    access_res_e               chk_res;

    // Bank response and lock state
    logic                      rsp_valid;
    logic [SOC_IFC_DATA_W-1:0] rsp_rdata;
    logic                      rsp_err;
    logic                      fuse_done;
    logic                      pauser_lock;
    logic                      trng_lock;
    logic [SOC_IFC_USER_W-1:0] trng_valid_user;

    apb_req_stage #(
        .APB_ADDR_WIDTH (APB_ADDR_WIDTH)
    ) u_apb_req_stage (
        .clk                 (clk),
        .cptra_noncore_rst_b (cptra_noncore_rst_b),
        .paddr_i             (paddr_i),
        .psel_i              (psel_i),
        .penable_i           (penable_i),
        .pwrite_i            (pwrite_i),
        .pwdata_i            (pwdata_i),
        .pauser_i            (pauser_i),
        .pready_o            (pready_o),
        .prdata_o            (prdata_o),
        .pslverr_o           (pslverr_o),
        .rsp_valid_i         (rsp_valid),
        .rsp_rdata_i         (rsp_rdata),
        .rsp_err_i           (rsp_err),
        .req_valid_o         (req_valid),
        .req_op_o            (req_op),
        .req_addr_o          (req_addr),
        .req_wdata_o         (req_wdata),
        .req_user_o          (req_user)
    );

    access_check_stage #(
        .APB_ADDR_WIDTH (APB_ADDR_WIDTH),
        .UDS_WORDS      (UDS_WORDS),
        .TRNG_WORDS     (TRNG_WORDS)
    ) u_access_check_stage (
        .clk                 (clk),
        .cptra_noncore_rst_b (cptra_noncore_rst_b),
        .req_valid_i         (req_valid),
        .req_op_i            (req_op),
        .req_addr_i          (req_addr),
        .req_wdata_i         (req_wdata),
        .req_user_i          (req_user),
        .fuse_done_i         (fuse_done),
        .pauser_lock_i       (pauser_lock),
        .trng_lock_i         (trng_lock),
        .trng_valid_user_i   (trng_valid_user),
        .chk_valid_o         (chk_valid),
        .chk_op_o            (chk_op),
        .chk_id_o            (chk_id),
        .chk_index_o         (chk_index),
        .chk_wdata_o         (chk_wdata),
        .chk_res_o           (chk_res)
    );

    fuse_reg_bank #(
        .UDS_WORDS  (UDS_WORDS),
        .TRNG_WORDS (TRNG_WORDS)
    ) u_fuse_reg_bank (
        .clk                 (clk),
        .cptra_noncore_rst_b (cptra_noncore_rst_b),
        .chk_valid_i         (chk_valid),
        .chk_op_i            (chk_op),
        .chk_id_i            (chk_id),
        .chk_index_i         (chk_index),
        .chk_wdata_i         (chk_wdata),
        .chk_res_i           (chk_res),
        .rsp_valid_o         (rsp_valid),
        .rsp_rdata_o         (rsp_rdata),
        .rsp_err_o           (rsp_err),
        .fuse_done_o         (fuse_done),
        .pauser_lock_o       (pauser_lock),
        .trng_lock_o         (trng_lock),
        .trng_valid_user_o   (trng_valid_user)
    );

endmodule

// ==== src.f ====
source/soc_ifc_cfg_pkg.sv
source/soc_ifc_access_pkg.sv
source/apb_req_stage.sv
source/access_check_stage.sv
source/fuse_reg_bank.sv
source/soc_ifc_regs_top.sv
sim/soc_ifc_regs_assert.sv
sim/soc_ifc_regs_tb.sv
